/* design/net_proto_pkg.sv */
package net_proto_pkg;

    // one IPv4 address, seen as octets or as display nibbles
    typedef union packed {
        logic [3:0][7:0] octets;
        logic [7:0][3:0] nibbles;
    } ipv4_addr_u;

    typedef logic [15:0] udp_port_t;

    typedef logic [15:0] udp_len_t;

    // datagrams to this port get echoed
    localparam udp_port_t ECHO_PORT = 16'd1234;

endpackage

/* design/echo_hw_pkg.sv */
package echo_hw_pkg;

    // payload byte width
    localparam int DATA_W = 8;

    // default depth of the loopback FIFO
    localparam int FIFO_DEPTH = 16;

    // board LED bank
    localparam int LED_W = 18;

    // seven-segment digits
    localparam int SEG_W = 7;
    localparam int HEX_DIGITS = 8;

    // digits on the board light on a low level
    localparam bit SEG_ACTIVE_LOW = 1'b1;

endpackage

/* design/udp_hdr_if.sv */
`timescale 1ns/100ps

interface udp_hdr_if;

    logic                      valid;
    logic                      ready;
    net_proto_pkg::ipv4_addr_u src_ip;
    net_proto_pkg::ipv4_addr_u dst_ip;
    net_proto_pkg::udp_port_t  src_port;
    net_proto_pkg::udp_port_t  dst_port;
    net_proto_pkg::udp_len_t   length;

    // fields hold while valid is high and ready is low
    modport src (
        output valid, src_ip, dst_ip, src_port, dst_port, length,
        input  ready
    );

    modport snk (
        input  valid, src_ip, dst_ip, src_port, dst_port, length,
        output ready
    );

endinterface

/* design/byte_stream_if.sv */
`timescale 1ns/100ps

interface byte_stream_if;

    logic [echo_hw_pkg::DATA_W-1:0] data;
    logic                           valid;
    logic                           ready;
    // last marks the final byte of a datagram
    logic                           last;
    logic                           user;

    modport src (output data, valid, last, user, input ready);

    modport snk (input data, valid, last, user, output ready);

endinterface

/* design/hex_digit_decoder.sv */
`timescale 1ns/100ps

module hex_digit_decoder #(
    parameter bit INVERT = 1'b0
) (
    input  logic [3:0] i_nibble,
    output logic [6:0] o_seg
);

    // segment a on bit 0 through g on bit 6, lit when 1
    logic [6:0] seg;

    always_comb begin
        case (i_nibble)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c;
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e;
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
    end

    assign o_seg = INVERT ? ~seg : seg;

endmodule

/* design/udp_port_filter.sv */
`timescale 1ns/100ps

module udp_port_filter (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_hdr_valid,
    output logic                           o_hdr_ready,
    input  net_proto_pkg::ipv4_addr_u      i_src_ip,
    input  net_proto_pkg::ipv4_addr_u      i_dst_ip,
    input  net_proto_pkg::udp_port_t       i_src_port,
    input  net_proto_pkg::udp_port_t       i_dst_port,
    input  net_proto_pkg::udp_len_t        i_length,
    input  logic [echo_hw_pkg::DATA_W-1:0] i_data,
    input  logic                           i_valid,
    output logic                           o_ready,
    input  logic                           i_last,
    input  logic                           i_user,
    udp_hdr_if.src                         hdr_out,
    byte_stream_if.src                     pay_out
);

    // frame tracker, idle when neither flag is set
    logic pass_r;
    logic drop_r;
    logic idle;
    logic match;
    logic hdr_fire;
    logic end_fire;

    assign idle  = !pass_r && !drop_r;
    assign match = (i_dst_port == net_proto_pkg::ECHO_PORT);

    // matching headers wait for a free reply slot, others are eaten at once
    assign o_hdr_ready = i_hdr_valid && idle && (match ? hdr_out.ready : 1'b1);
    assign hdr_fire    = i_hdr_valid && o_hdr_ready;

    assign hdr_out.valid    = i_hdr_valid && idle && match;
    assign hdr_out.src_ip   = i_src_ip;
    assign hdr_out.dst_ip   = i_dst_ip;
    assign hdr_out.src_port = i_src_port;
    assign hdr_out.dst_port = i_dst_port;
    assign hdr_out.length   = i_length;

    // drop drains freely, pass follows the FIFO
    assign o_ready       = drop_r || (pass_r && pay_out.ready);
    assign pay_out.valid = i_valid && pass_r;
    assign pay_out.data  = i_data;
    assign pay_out.last  = i_last;
    assign pay_out.user  = i_user;

    assign end_fire = i_valid && o_ready && i_last;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pass_r <= 1'b0;
            drop_r <= 1'b0;
        end else if (hdr_fire) begin
            pass_r <= match;
            drop_r <= !match;
        end else if (end_fire) begin
            pass_r <= 1'b0;
            drop_r <= 1'b0;
        end
    end

    // payload only moves once its header has been taken
    // the next payload waits for a new header
    a_idle_after_last: assert property (@(posedge i_clk) disable iff (i_rst)
        end_fire |=> idle);

endmodule

/* design/udp_reply_header.sv */
`timescale 1ns/100ps

module udp_reply_header (
    input  logic                      i_clk,
    input  logic                      i_rst,
    udp_hdr_if.snk                    hdr_in,
    output logic                      o_tx_hdr_valid,
    input  logic                      i_tx_hdr_ready,
    output net_proto_pkg::ipv4_addr_u o_tx_src_ip,
    output net_proto_pkg::ipv4_addr_u o_tx_dst_ip,
    output net_proto_pkg::udp_port_t  o_tx_src_port,
    output net_proto_pkg::udp_port_t  o_tx_dst_port,
    output net_proto_pkg::udp_len_t   o_tx_length
);

    // one-entry slot, only takes a header when empty
    assign hdr_in.ready = !o_tx_hdr_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_tx_hdr_valid <= 1'b0;
        end else if (hdr_in.valid && hdr_in.ready) begin
            o_tx_hdr_valid <= 1'b1;
        end else if (i_tx_hdr_ready) begin
            o_tx_hdr_valid <= 1'b0;
        end
    end

    // reply goes back to the sender with ports swapped
    always_ff @(posedge i_clk) begin
        if (hdr_in.valid && hdr_in.ready) begin
            o_tx_src_ip   <= hdr_in.dst_ip;
            o_tx_dst_ip   <= hdr_in.src_ip;
            o_tx_src_port <= hdr_in.dst_port;
            o_tx_dst_port <= hdr_in.src_port;
            o_tx_length   <= hdr_in.length;
        end
    end

    a_hdr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_tx_hdr_valid && !i_tx_hdr_ready |=> o_tx_hdr_valid
            && $stable(o_tx_src_ip) && $stable(o_tx_dst_ip)
            && $stable(o_tx_src_port) && $stable(o_tx_dst_port)
            && $stable(o_tx_length));

endmodule

/* design/udp_payload_fifo.sv */
`timescale 1ns/100ps

module udp_payload_fifo #(
    parameter int DEPTH = echo_hw_pkg::FIFO_DEPTH
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    byte_stream_if.snk                     wr,
    output logic [echo_hw_pkg::DATA_W-1:0] o_data,
    output logic                           o_valid,
    input  logic                           i_ready,
    output logic                           o_last,
    output logic                           o_user
);

    // entry is {user, last, data}
    logic [echo_hw_pkg::DATA_W+1:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]       wr_ptr;
    logic [$clog2(DEPTH)-1:0]       rd_ptr;
    logic [$clog2(DEPTH):0]         count;
    logic                           wr_fire;
    logic                           rd_fire;

    assign wr.ready = (count != DEPTH);
    assign o_valid  = (count != 0);
    assign wr_fire  = wr.valid && wr.ready;
    assign rd_fire  = o_valid && i_ready;

    assign {o_user, o_last, o_data} = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr.user, wr.last, wr.data};
        end
    end

    // pointers wrap naturally at a power-of-two depth
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + wr_fire - rd_fire;
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
        count <= DEPTH);

    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
        (count == 0) && !wr_fire |=> (count == 0));

endmodule

/* design/udp_status_display.sv */
`timescale 1ns/100ps

module udp_status_display (
    input  logic                                                 i_clk,
    input  logic                                                 i_rst,
    input  logic                                                 i_hdr_fire,
    input  net_proto_pkg::ipv4_addr_u                            i_dst_ip,
    input  logic                                                 i_beat_fire,
    input  logic [echo_hw_pkg::DATA_W-1:0]                       i_beat_data,
    input  logic                                                 i_beat_last,
    output logic [echo_hw_pkg::LED_W-1:0]                        o_led,
    output logic [echo_hw_pkg::HEX_DIGITS*echo_hw_pkg::SEG_W-1:0] o_hex
);

    // high while inside a reply, so only the first byte is latched
    logic                      in_frame_r;
    net_proto_pkg::ipv4_addr_u ip_r;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_frame_r <= 1'b0;
            o_led      <= '0;
        end else if (i_beat_fire) begin
            if (!in_frame_r) begin
                o_led <= {{(echo_hw_pkg::LED_W-echo_hw_pkg::DATA_W){1'b0}}, i_beat_data};
            end
            in_frame_r <= !i_beat_last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ip_r <= '0;
        end else if (i_hdr_fire) begin
            ip_r <= i_dst_ip;
        end
    end

    // nibble k drives digit k
    for (genvar k = 0; k < echo_hw_pkg::HEX_DIGITS; k++) begin : g_digit
        hex_digit_decoder #(
            .INVERT(echo_hw_pkg::SEG_ACTIVE_LOW)
        ) u_digit (
            .i_nibble(ip_r.nibbles[k]),
            .o_seg   (o_hex[k*echo_hw_pkg::SEG_W +: echo_hw_pkg::SEG_W])
        );
    end

endmodule

/* design/udp_echo_top.sv */
`timescale 1ns/100ps

module udp_echo_top (
    input  logic                                                  i_clk,
    input  logic                                                  i_rst,
    input  logic                                                  i_rx_hdr_valid,
    output logic                                                  o_rx_hdr_ready,
    input  logic [$bits(net_proto_pkg::ipv4_addr_u)-1:0]           i_rx_src_ip,
    input  logic [$bits(net_proto_pkg::ipv4_addr_u)-1:0]           i_rx_dst_ip,
    input  logic [$bits(net_proto_pkg::udp_port_t)-1:0]            i_rx_src_port,
    input  logic [$bits(net_proto_pkg::udp_port_t)-1:0]            i_rx_dst_port,
    input  logic [$bits(net_proto_pkg::udp_len_t)-1:0]             i_rx_length,
    input  logic [echo_hw_pkg::DATA_W-1:0]                         i_rx_data,
    input  logic                                                  i_rx_valid,
    output logic                                                  o_rx_ready,
    input  logic                                                  i_rx_last,
    input  logic                                                  i_rx_user,
    output logic                                                  o_tx_hdr_valid,
    input  logic                                                  i_tx_hdr_ready,
    output logic [$bits(net_proto_pkg::ipv4_addr_u)-1:0]           o_tx_src_ip,
    output logic [$bits(net_proto_pkg::ipv4_addr_u)-1:0]           o_tx_dst_ip,
    output logic [$bits(net_proto_pkg::udp_port_t)-1:0]            o_tx_src_port,
    output logic [$bits(net_proto_pkg::udp_port_t)-1:0]            o_tx_dst_port,
    output logic [$bits(net_proto_pkg::udp_len_t)-1:0]             o_tx_length,
    output logic [echo_hw_pkg::DATA_W-1:0]                         o_tx_data,
    output logic                                                  o_tx_valid,
    input  logic                                                  i_tx_ready,
    output logic                                                  o_tx_last,
    output logic                                                  o_tx_user,
    output logic [echo_hw_pkg::LED_W-1:0]                          o_led,
    output logic [echo_hw_pkg::HEX_DIGITS*echo_hw_pkg::SEG_W-1:0]  o_hex
);

    udp_hdr_if     req_hdr ();
    byte_stream_if req_pay ();

    udp_port_filter u_filter (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_hdr_valid(i_rx_hdr_valid),
        .o_hdr_ready(o_rx_hdr_ready),
        .i_src_ip   (i_rx_src_ip),
        .i_dst_ip   (i_rx_dst_ip),
        .i_src_port (i_rx_src_port),
        .i_dst_port (i_rx_dst_port),
        .i_length   (i_rx_length),
        .i_data     (i_rx_data),
        .i_valid    (i_rx_valid),
        .o_ready    (o_rx_ready),
        .i_last     (i_rx_last),
        .i_user     (i_rx_user),
        .hdr_out    (req_hdr),
        .pay_out    (req_pay)
    );

    udp_reply_header u_reply (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .hdr_in        (req_hdr),
        .o_tx_hdr_valid(o_tx_hdr_valid),
        .i_tx_hdr_ready(i_tx_hdr_ready),
        .o_tx_src_ip   (o_tx_src_ip),
        .o_tx_dst_ip   (o_tx_dst_ip),
        .o_tx_src_port (o_tx_src_port),
        .o_tx_dst_port (o_tx_dst_port),
        .o_tx_length   (o_tx_length)
    );

    udp_payload_fifo u_fifo (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .wr     (req_pay),
        .o_data (o_tx_data),
        .o_valid(o_tx_valid),
        .i_ready(i_tx_ready),
        .o_last (o_tx_last),
        .o_user (o_tx_user)
    );

    // transfers seen on the reply side
    udp_status_display u_status (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_hdr_fire (o_tx_hdr_valid && i_tx_hdr_ready),
        .i_dst_ip   (o_tx_dst_ip),
        .i_beat_fire(o_tx_valid && i_tx_ready),
        .i_beat_data(o_tx_data),
        .i_beat_last(o_tx_last),
        .o_led      (o_led),
        .o_hex      (o_hex)
    );

endmodule

/* verification/udp_echo_tb.sv */
`timescale 1ns/100ps

module udp_echo_tb;

    localparam int NUM_FRAMES = 12;
    localparam int MAX_BYTES  = 24;
    // reset plus 8 stall cycles per byte and header beat
    localparam int MAX_CYCLES = 16 + NUM_FRAMES * (MAX_BYTES + 4) * 8;
    // segments a..g on bits 0..6, lit when 1
    localparam logic [6:0] SEG_LIT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
        7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
    localparam logic [55:0] HEX_ZERO = {8{7'h40}};

    logic        i_clk = 1'b0;
    logic        i_rst = 1'b1;
    logic        i_rx_hdr_valid, i_rx_valid, i_rx_last, i_rx_user;
    logic        i_tx_hdr_ready, i_tx_ready;
    logic [31:0] i_rx_src_ip, i_rx_dst_ip;
    logic [15:0] i_rx_src_port, i_rx_dst_port, i_rx_length;
    logic [7:0]  i_rx_data;
    logic        o_rx_hdr_ready, o_rx_ready, o_tx_hdr_valid, o_tx_valid, o_tx_last, o_tx_user;
    logic [31:0] o_tx_src_ip, o_tx_dst_ip;
    logic [15:0] o_tx_src_port, o_tx_dst_port, o_tx_length;
    logic [7:0]  o_tx_data;
    logic [17:0] o_led;
    logic [55:0] o_hex;

    // expected reply header {src_ip, dst_ip, src_port, dst_port, length}
    logic [111:0] hdr_q [$];
    // expected reply byte {user, last, data}
    logic [9:0]   beat_q [$];
    logic [111:0] exp_hdr;
    logic [9:0]   exp_beat;
    logic         hdr_avail, beat_avail, in_reply;
    logic [17:0]  exp_led;
    logic [55:0]  exp_hex;
    logic         hdr_fire_mid = 1'b0;
    logic         beat_fire_mid = 1'b0;
    int           cycles = 0;
    logic         hdr_fire, beat_fire;
    logic [111:0] tx_hdr;

    assign hdr_fire  = o_tx_hdr_valid && i_tx_hdr_ready;
    assign beat_fire = o_tx_valid && i_tx_ready;
    assign tx_hdr    = {o_tx_src_ip, o_tx_dst_ip, o_tx_src_port, o_tx_dst_port, o_tx_length};

    udp_echo_top u_udp_echo_top (.*);

    always #10 i_clk = ~i_clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic logic [55:0] hex_for_ip(input logic [31:0] ip);
        logic [55:0] hex;
        for (int k = 0; k < 8; k++) begin
            hex[k*7 +: 7] = ~SEG_LIT[ip[k*4 +: 4]];
        end
        return hex;
    endfunction

    task automatic refresh_front();
        hdr_avail  = (hdr_q.size() != 0);
        beat_avail = (beat_q.size() != 0);
        if (hdr_avail) exp_hdr = hdr_q[0];
        if (beat_avail) exp_beat = beat_q[0];
    endtask

    // ready is looked at mid-cycle, where it is settled
    task automatic wait_ready(input bit for_hdr);
        logic done;
        do begin
            @(negedge i_clk);
            done = for_hdr ? o_rx_hdr_ready : o_rx_ready;
            @(posedge i_clk);
            #2;
        end while (!done);
    endtask

    task automatic send_datagram(input bit to_echo);
        int         n;
        logic [7:0] b;
        n = 1 + $urandom % MAX_BYTES;
        i_rx_src_ip   = $urandom;
        i_rx_dst_ip   = $urandom;
        i_rx_src_port = $urandom;
        i_rx_dst_port = to_echo ? 16'd1234 : 16'd1235 + 16'($urandom % 4000);
        i_rx_length   = 16'(8 + n);
        i_rx_user     = $urandom % 2;
        // reply swaps ports and addresses, length unchanged
        if (to_echo) begin
            hdr_q.push_back({i_rx_dst_ip, i_rx_src_ip, i_rx_dst_port, i_rx_src_port,
                i_rx_length});
            refresh_front();
        end
        i_rx_hdr_valid = 1'b1;
        wait_ready(1'b1);
        i_rx_hdr_valid = 1'b0;
        for (int j = 0; j < n; j++) begin
            if ($urandom % 4 == 0) begin
                @(posedge i_clk);
                #2;
            end
            b = $urandom;
            if (to_echo) begin
                beat_q.push_back({i_rx_user, j == n - 1, b});
                refresh_front();
            end
            i_rx_valid = 1'b1;
            i_rx_data  = b;
            i_rx_last  = (j == n - 1);
            wait_ready(1'b0);
            i_rx_valid = 1'b0;
        end
    endtask

    // random back-pressure on both reply channels
    always @(posedge i_clk) begin
        #2;
        i_tx_hdr_ready = $urandom % 2;
        i_tx_ready     = ($urandom % 3 != 0);
    end

    always @(negedge i_clk) begin
        hdr_fire_mid  = hdr_fire;
        beat_fire_mid = beat_fire;
    end

    // scoreboard pops after the edge that the assertions sampled
    always @(posedge i_clk) begin
        if (hdr_fire_mid && hdr_avail) begin
            exp_hex = hex_for_ip(exp_hdr[79:48]);
            void'(hdr_q.pop_front());
        end
        if (beat_fire_mid && beat_avail) begin
            if (!in_reply) exp_led = {10'b0, exp_beat[7:0]};
            in_reply = !exp_beat[8];
            void'(beat_q.pop_front());
        end
        refresh_front();
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, not every reply arrived",
                cycles));
        end
    end

    a_reset_ctrl: assert property (@(posedge i_clk) $fell(i_rst) |->
        !o_rx_hdr_ready && !o_rx_ready && !o_tx_hdr_valid && !o_tx_valid)
        else report_failure("a ready or valid output was high right after reset");
    a_reset_led: assert property (@(posedge i_clk) $fell(i_rst) |-> o_led == '0)
        else report_failure($sformatf("** Error at %0t: o_led expected %h, got %h",
            $time, 18'h0, $sampled(o_led)));
    a_reset_hex: assert property (@(posedge i_clk) $fell(i_rst) |-> o_hex == HEX_ZERO)
        else report_failure($sformatf("** Error at %0t: o_hex expected %h, got %h",
            $time, HEX_ZERO, $sampled(o_hex)));
    a_hdr_expected: assert property (@(posedge i_clk) disable iff (i_rst)
        hdr_fire |-> hdr_avail)
        else report_failure("reply header sent with no echo request pending");
    a_hdr_fields: assert property (@(posedge i_clk) disable iff (i_rst)
        hdr_fire && hdr_avail |-> tx_hdr == exp_hdr)
        else report_failure($sformatf("** Error at %0t: reply header expected %h, got %h",
            $time, $sampled(exp_hdr), $sampled(tx_hdr)));
    a_beat_expected: assert property (@(posedge i_clk) disable iff (i_rst)
        beat_fire |-> beat_avail)
        else report_failure("reply byte sent with no echo payload pending");
    a_beat_value: assert property (@(posedge i_clk) disable iff (i_rst)
        beat_fire && beat_avail |-> {o_tx_user, o_tx_last, o_tx_data} == exp_beat)
        else report_failure($sformatf(
            "** Error at %0t: {o_tx_user,o_tx_last,o_tx_data} expected %h, got %h",
            $time, $sampled(exp_beat), $sampled({o_tx_user, o_tx_last, o_tx_data})));
    a_led_first: assert property (@(posedge i_clk) disable iff (i_rst)
        beat_fire && beat_avail && !in_reply |=> o_led == exp_led)
        else report_failure($sformatf("** Error at %0t: o_led expected %h, got %h",
            $time, $sampled(exp_led), $sampled(o_led)));
    a_hex_ip: assert property (@(posedge i_clk) disable iff (i_rst)
        hdr_fire && hdr_avail |=> o_hex == exp_hex)
        else report_failure($sformatf("** Error at %0t: o_hex expected %h, got %h",
            $time, $sampled(exp_hex), $sampled(o_hex)));

    initial begin
        void'($urandom(89));
        i_rx_hdr_valid = 1'b0;
        i_rx_valid     = 1'b0;
        i_rx_last      = 1'b0;
        i_rx_user      = 1'b0;
        i_rx_data      = '0;
        i_rx_src_ip    = '0;
        i_rx_dst_ip    = '0;
        i_rx_src_port  = '0;
        i_rx_dst_port  = '0;
        i_rx_length    = '0;
        i_tx_hdr_ready = 1'b0;
        i_tx_ready     = 1'b0;
        exp_hdr        = '0;
        exp_beat       = '0;
        exp_led        = '0;
        exp_hex        = HEX_ZERO;
        in_reply       = 1'b0;
        refresh_front();
        repeat (16) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        repeat (2) @(posedge i_clk);
        #2;
        // frame 1 always goes to another port so the drain path runs
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_datagram(!(i == 1 || $urandom % 3 == 0));
        end
        do begin
            @(negedge i_clk);
        end while (hdr_q.size() != 0 || beat_q.size() != 0);
        repeat (4) @(negedge i_clk);
        if (!o_tx_valid && !o_tx_hdr_valid) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_failure("reply output still valid after every expected reply was sent");
        end
    end

endmodule

/* udp_echo_top.f */
design/net_proto_pkg.sv
design/echo_hw_pkg.sv
design/udp_hdr_if.sv
design/byte_stream_if.sv
design/hex_digit_decoder.sv
design/udp_port_filter.sv
design/udp_reply_header.sv
design/udp_payload_fifo.sv
design/udp_status_display.sv
design/udp_echo_top.sv
verification/udp_echo_tb.sv
